// File: pcie_cfg_sidecar.f
+incdir+src
src/pcie_cfg_pkg.sv
src/cfg_skp_lfsr_disable.sv
src/flr_done_pulser.sv
src/pcie_func_responder.sv
src/pcie_cfg_sidecar.sv
testbench/tb_pcie_cfg_sidecar.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sidecar testbench with Verilator and runs it.
# The exit status is the simulator's: zero on pass, non-zero on any failure.

set -u

TOP=tb_pcie_cfg_sidecar
OBJ_DIR=obj_dir
FILE_LIST=pcie_cfg_sidecar.f

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
  echo "cannot enter the project root"
  exit $status
fi

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module "$TOP" -Mdir "$OBJ_DIR" -f "$FILE_LIST"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: testbench/tb_pcie_cfg_sidecar.sv
// models the core's config side; each table row restarts from reset and runs one full fix-up
module tb_pcie_cfg_sidecar import pcie_cfg_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // run shape
  // ------------------------------

  localparam int num_rows     = 4;
  localparam int reset_cycles = 16;
  localparam int flr_steps    = 4;   // mask steps per row
  localparam int step_hold    = 3;   // cycles each step is held
  localparam int pwr_len      = 16;  // cycles of power request pattern
  localparam int stim_len     = 18;  // covers flr and power stimulus
  localparam int idle_cycles  = 30;  // quiet port after the write
  localparam int stray_at     = 10;  // idle cycle that gets a stray done

  typedef struct packed {
    int                           read_lat;    // cycles from read strobe to done
    cfg_data_t                    read_data;
    cfg_data_t                    write_data;  // expected, disable bit merged in
    int                           write_lat;
    pf_mask_t [flr_steps-1:0]     pf_seq;      // step 0 in the low bits
    vf_mask_t [flr_steps-1:0]     vf_seq;
    logic [pwr_len-1:0]           pwr_pat;     // bit n drives cycle n
  } row_t;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic      user_clk;
  logic      user_reset;
  cfg_data_t cfg_mgmt_read_data;
  logic      cfg_mgmt_read_write_done;
  cfg_addr_t cfg_mgmt_addr;
  cfg_data_t cfg_mgmt_write_data;
  cfg_be_t   cfg_mgmt_byte_enable;
  logic      cfg_mgmt_read;
  logic      cfg_mgmt_write;
  pf_mask_t  cfg_flr_in_process;
  vf_mask_t  cfg_vf_flr_in_process;
  pf_mask_t  cfg_flr_done;
  vf_mask_t  cfg_vf_flr_done;
  logic      cfg_power_state_change_interrupt;
  logic      cfg_power_state_change_ack;

  // ------------------------------
  // testbench state
  // ------------------------------

  row_t         table_rows [num_rows];
  bit           table_loaded = 1'b0;
  integer       seed;

  fixup_state_t exp_state;    // where the fix-up should be
  logic         read_issued;
  logic         exp_read;
  logic         exp_write;
  cfg_addr_t    exp_addr;
  cfg_data_t    exp_data;
  cfg_be_t      exp_be;

  pf_mask_t     pf_now;       // flags sampled at the last edge
  pf_mask_t     pf_prev;      // and the edge before
  vf_mask_t     vf_now;
  vf_mask_t     vf_prev;
  logic         pwr_now;

  int           strobe_age;   // cycles the current access has been up
  logic         done_drive;   // done value driven for the coming edge
  int           cycle;
  int           idle_count;

  pcie_cfg_sidecar dut (
    .user_clk                         (user_clk),
    .user_reset                       (user_reset),
    .cfg_mgmt_read_data               (cfg_mgmt_read_data),
    .cfg_mgmt_read_write_done         (cfg_mgmt_read_write_done),
    .cfg_mgmt_addr                    (cfg_mgmt_addr),
    .cfg_mgmt_write_data              (cfg_mgmt_write_data),
    .cfg_mgmt_byte_enable             (cfg_mgmt_byte_enable),
    .cfg_mgmt_read                    (cfg_mgmt_read),
    .cfg_mgmt_write                   (cfg_mgmt_write),
    .cfg_flr_in_process               (cfg_flr_in_process),
    .cfg_vf_flr_in_process            (cfg_vf_flr_in_process),
    .cfg_flr_done                     (cfg_flr_done),
    .cfg_vf_flr_done                  (cfg_vf_flr_done),
    .cfg_power_state_change_interrupt (cfg_power_state_change_interrupt),
    .cfg_power_state_change_ack       (cfg_power_state_change_ack)
  );

  always #5 user_clk = ~user_clk;  // 100 MHz

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // steps are written last step first
  task automatic load_table();
    table_rows[0] = '{read_lat: 1, read_data: 32'h0000_0000, write_data: 32'h0800_0000,
                      write_lat: 1, pf_seq: {2'b00, 2'b10, 2'b11, 2'b01},
                      vf_seq: {6'b000000, 6'b100010, 6'b000011, 6'b000001},
                      pwr_pat: 16'hA5C3};
    table_rows[1] = '{read_lat: 5, read_data: 32'hF7FF_FFFF, write_data: 32'hFFFF_FFFF,
                      write_lat: 2, pf_seq: {2'b11, 2'b11, 2'b00, 2'b11},
                      vf_seq: {6'b010101, 6'b101010, 6'b000000, 6'b111111},
                      pwr_pat: 16'h0FF0};
    table_rows[2] = '{read_lat: 12, read_data: 32'h1234_5678, write_data: 32'h1A34_5678,
                      write_lat: 7, pf_seq: {2'b00, 2'b01, 2'b10, 2'b10},
                      vf_seq: {6'b000011, 6'b001100, 6'b110000, 6'b010000},
                      pwr_pat: 16'h8001};
    table_rows[3] = '{read_lat: 3, read_data: 32'h0C00_0001, write_data: 32'h0C00_0001,
                      write_lat: 20, pf_seq: {2'b10, 2'b00, 2'b01, 2'b00},
                      vf_seq: {6'b111110, 6'b011111, 6'b000000, 6'b100000},
                      pwr_pat: 16'h5555};
  endtask

  // holds reset with random inputs; returns on the negedge that releases it
  task automatic apply_reset();
    logic [31:0] rnd;
    user_reset               = 1'b1;
    cfg_mgmt_read_write_done = 1'b0;
    repeat (reset_cycles) begin
      rnd                              = $random(seed);
      cfg_mgmt_read_data               = rnd;
      cfg_flr_in_process               = rnd[1:0];
      cfg_vf_flr_in_process            = rnd[7:2];
      cfg_power_state_change_interrupt = rnd[8];  // ack must still come out low
      @(negedge user_clk);
    end
    user_reset = 1'b0;
  endtask

  task automatic clear_expected();
    exp_state   = fixup_reading;
    read_issued = 1'b0;
    exp_read    = 1'b0;
    exp_write   = 1'b0;
    exp_addr    = '0;
    exp_data    = '0;
    exp_be      = '0;
    pf_now      = '0;  // pulser registers come out of reset clear
    pf_prev     = '0;
    vf_now      = '0;
    vf_prev     = '0;
    pwr_now     = 1'b0;
    strobe_age  = 0;
    done_drive  = 1'b0;
    cycle       = 0;
    idle_count  = 0;
  endtask

  // ------------------------------
  // one clock cycle at the negedge
  // ------------------------------

  task automatic step_cycle(input row_t row, input int r);
    logic       done_next;
    int         lat;
    logic [1:0] step_idx;
    logic [3:0] pwr_idx;
    pf_mask_t   pf_drive;
    vf_mask_t   vf_drive;
    logic       pwr_drive;

    // outputs after the last posedge
    check_value("cfg_mgmt_read", 32'(cfg_mgmt_read), 32'(exp_read));
    check_value("cfg_mgmt_write", 32'(cfg_mgmt_write), 32'(exp_write));
    check_value("cfg_mgmt_addr", 32'(cfg_mgmt_addr), 32'(exp_addr));
    check_value("cfg_mgmt_write_data", cfg_mgmt_write_data, exp_data);
    check_value("cfg_mgmt_byte_enable", 32'(cfg_mgmt_byte_enable), 32'(exp_be));
    check_value("cfg_flr_done", 32'(cfg_flr_done), 32'(pf_now & ~pf_prev));
    check_value("cfg_vf_flr_done", 32'(cfg_vf_flr_done), 32'(vf_now & ~vf_prev));
    check_value("cfg_power_state_change_ack", 32'(cfg_power_state_change_ack),
                32'(pwr_now));
    if (exp_state == fixup_finished) begin
      idle_count++;
    end

    // config-space model
    if (done_drive) begin
      strobe_age = 0;  // previous access just completed
    end
    done_next = 1'b0;
    if (cfg_mgmt_read || cfg_mgmt_write) begin
      strobe_age++;
      lat       = cfg_mgmt_read ? row.read_lat : row.write_lat;
      done_next = (strobe_age == lat);
    end else if (exp_state == fixup_finished && idle_count == stray_at) begin
      done_next = 1'b1;  // nothing outstanding
      $display("row %0d: stray done at cycle %0d", r, cycle);
    end
    if (done_next && cfg_mgmt_read) begin
      cfg_mgmt_read_data = row.read_data;
    end else begin
      cfg_mgmt_read_data = $random(seed);  // filler the DUT must ignore
    end

    // expected management outputs after the coming edge
    if (!read_issued) begin
      read_issued = 1'b1;
      exp_read    = 1'b1;
      exp_addr    = 19'h40082;
      exp_be      = 4'hF;
    end else if (done_next && exp_state == fixup_reading) begin
      exp_read  = 1'b0;
      exp_write = 1'b1;
      exp_data  = row.write_data;
      exp_state = fixup_writing;
    end else if (done_next && exp_state == fixup_writing) begin
      exp_write = 1'b0;
      exp_addr  = '0;
      exp_data  = '0;
      exp_be    = '0;
      exp_state = fixup_finished;
      $display("row %0d: fix-up %s at cycle %0d", r, exp_state.name(), cycle);
    end

    // flr and power stimulus
    if (cycle < flr_steps * step_hold) begin
      step_idx = 2'(cycle / step_hold);
      pf_drive = row.pf_seq[step_idx];
      vf_drive = row.vf_seq[step_idx];
    end else begin
      pf_drive = '0;
      vf_drive = '0;
    end
    if (cycle < pwr_len) begin
      pwr_idx   = 4'(cycle);
      pwr_drive = row.pwr_pat[pwr_idx];
    end else begin
      pwr_drive = 1'b0;
    end
    pf_prev = pf_now;
    pf_now  = pf_drive;
    vf_prev = vf_now;
    vf_now  = vf_drive;
    pwr_now = pwr_drive;

    cfg_flr_in_process               = pf_drive;
    cfg_vf_flr_in_process            = vf_drive;
    cfg_power_state_change_interrupt = pwr_drive;
    cfg_mgmt_read_write_done         = done_next;
    done_drive                       = done_next;
    cycle++;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin : main
    row_t cur;
    user_clk                         = 1'b0;
    user_reset                       = 1'b1;
    cfg_mgmt_read_data               = '0;
    cfg_mgmt_read_write_done         = 1'b0;
    cfg_flr_in_process               = '0;
    cfg_vf_flr_in_process            = '0;
    cfg_power_state_change_interrupt = 1'b0;
    seed                             = 32'h49759bec;
    load_table();
    table_loaded = 1'b1;

    for (int r = 0; r < num_rows; r++) begin
      cur = table_rows[2'(r)];
      apply_reset();
      clear_expected();
      while (!(exp_state == fixup_finished && idle_count >= idle_cycles &&
               cycle >= stim_len)) begin
        step_cycle(cur, r);
        @(negedge user_clk);
      end
      $display("row %0d: complete after %0d cycles", r, cycle);
    end

    $display("TEST PASSED");
    $finish;
  end

  // ------------------------------
  // watchdog
  // ------------------------------

  initial begin : watchdog
    int max_lat;
    int limit_cycles;
    wait (table_loaded);
    max_lat = 0;
    for (int r = 0; r < num_rows; r++) begin
      if (table_rows[2'(r)].read_lat > max_lat) begin
        max_lat = table_rows[2'(r)].read_lat;
      end
      if (table_rows[2'(r)].write_lat > max_lat) begin
        max_lat = table_rows[2'(r)].write_lat;
      end
    end
    limit_cycles = num_rows * (reset_cycles + max_lat * 2 + 40);
    #(limit_cycles * 10);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: src/pcie_cfg_sidecar.sv
// user_clk domain only; connect directly to the core's cfg ports with no extra pipelining
module pcie_cfg_sidecar import pcie_cfg_pkg::*; (
  input  logic      user_clk,
  input  logic      user_reset,

  // management port
  input  cfg_data_t cfg_mgmt_read_data,
  input  logic      cfg_mgmt_read_write_done,
  output cfg_addr_t cfg_mgmt_addr,
  output cfg_data_t cfg_mgmt_write_data,
  output cfg_be_t   cfg_mgmt_byte_enable,
  output logic      cfg_mgmt_read,
  output logic      cfg_mgmt_write,

  // function level reset
  input  pf_mask_t  cfg_flr_in_process,
  input  vf_mask_t  cfg_vf_flr_in_process,
  output pf_mask_t  cfg_flr_done,
  output vf_mask_t  cfg_vf_flr_done,

  // power management
  input  logic      cfg_power_state_change_interrupt,
  output logic      cfg_power_state_change_ack
);

  // ------------------------------
  // config fix-up after reset
  // ------------------------------

  cfg_skp_lfsr_disable skp_fixup (
    .user_clk                 (user_clk),
    .user_reset               (user_reset),
    .cfg_mgmt_read_data       (cfg_mgmt_read_data),
    .cfg_mgmt_read_write_done (cfg_mgmt_read_write_done),
    .cfg_mgmt_addr            (cfg_mgmt_addr),
    .cfg_mgmt_write_data      (cfg_mgmt_write_data),
    .cfg_mgmt_byte_enable     (cfg_mgmt_byte_enable),
    .cfg_mgmt_read            (cfg_mgmt_read),
    .cfg_mgmt_write           (cfg_mgmt_write)
  );

  // ------------------------------
  // per-function responses
  // ------------------------------

  pcie_func_responder func_resp (
    .user_clk                         (user_clk),
    .user_reset                       (user_reset),
    .cfg_flr_in_process               (cfg_flr_in_process),
    .cfg_vf_flr_in_process            (cfg_vf_flr_in_process),
    .cfg_power_state_change_interrupt (cfg_power_state_change_interrupt),
    .cfg_flr_done                     (cfg_flr_done),
    .cfg_vf_flr_done                  (cfg_vf_flr_done),
    .cfg_power_state_change_ack       (cfg_power_state_change_ack)
  );

endmodule

// File: src/pcie_func_responder.sv
// answers FLR and power-state requests immediately; no traffic is tracked before acking
module pcie_func_responder import pcie_cfg_pkg::*; (
  input  logic     user_clk,
  input  logic     user_reset,
  // from the core
  input  pf_mask_t cfg_flr_in_process,
  input  vf_mask_t cfg_vf_flr_in_process,
  input  logic     cfg_power_state_change_interrupt,
  // back to the core
  output pf_mask_t cfg_flr_done,
  output vf_mask_t cfg_vf_flr_done,
  output logic     cfg_power_state_change_ack
);

  // ------------------------------
  // function level reset
  // ------------------------------

  flr_done_pulser #(
    .mask_t (pf_mask_t)
  ) pf_flr_pulser (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .in_process (cfg_flr_in_process),
    .done       (cfg_flr_done)
  );

  flr_done_pulser #(
    .mask_t (vf_mask_t)
  ) vf_flr_pulser (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .in_process (cfg_vf_flr_in_process),
    .done       (cfg_vf_flr_done)
  );

  // ------------------------------
  // power state acknowledge
  // ------------------------------

  // With no completions ever left pending on this side, the core may
  // move to the new power state right away. The ack is simply the
  // request delayed by one register.
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      cfg_power_state_change_ack <= 1'b0;
    end else begin
      cfg_power_state_change_ack <= cfg_power_state_change_interrupt;  // follow request
    end
  end

endmodule

// File: src/flr_done_pulser.sv
// mask_t must be a packed vector; a done bit pulses in the cycle after the edge that first samples its flag high
module flr_done_pulser import pcie_cfg_pkg::*; #(
  parameter type mask_t = pf_mask_t  // one bit per function
) (
  input  logic  user_clk,
  input  logic  user_reset,
  input  mask_t in_process,  // level from the core
  output mask_t done         // one-cycle completion
);

  // ------------------------------
  // edge detect
  // ------------------------------

  mask_t flag_q;   // latest sample
  mask_t flag_qq;  // sample before that

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      flag_q  <= '0;
      flag_qq <= '0;
    end else begin
      flag_q  <= in_process;
      flag_qq <= flag_q;
    end
  end

  // Completion is reported as soon as the FLR is seen starting. Nothing
  // on this side holds state per function, so there is nothing to drain.
  assign done = flag_q & ~flag_qq;  // new rising bits only

  // ------------------------------
  // checks
  // ------------------------------

  // each pulse must trace back to a request the core actually raised
  assert property (@(posedge user_clk) disable iff (user_reset)
    (done & ~$past(in_process)) == '0)
    else $error("flr done without matching in-process flag");

endmodule

// File: src/cfg_skp_lfsr_disable.sv
// runs once per reset; expects exactly one done per strobe and no other master on the port
`include "pcie_cfg_defs.svh"

module cfg_skp_lfsr_disable import pcie_cfg_pkg::*; (
  input  logic      user_clk,
  input  logic      user_reset,
  // core side of the management port
  input  cfg_data_t cfg_mgmt_read_data,
  input  logic      cfg_mgmt_read_write_done,
  output cfg_addr_t cfg_mgmt_addr,
  output cfg_data_t cfg_mgmt_write_data,
  output cfg_be_t   cfg_mgmt_byte_enable,
  output logic      cfg_mgmt_read,
  output logic      cfg_mgmt_write
);

  // ------------------------------
  // constants
  // ------------------------------

  localparam cfg_addr_t fixup_addr   = `SKP_LFSR_REG_ADDR;
  localparam cfg_data_t disable_mask = cfg_data_t'(1) << `SKP_LFSR_DISABLE_BIT;

  fixup_state_t state;

  // ------------------------------
  // read-modify-write sequencer
  // ------------------------------

  // The read is raised on the first edge out of reset. The core may take
  // any number of cycles to answer; the strobe just stays up meanwhile.
  // The edge that samples done both drops the read and launches the write,
  // so the port never sees an idle cycle between the two accesses.
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state                <= fixup_reading;
      cfg_mgmt_addr        <= '0;
      cfg_mgmt_write_data  <= '0;
      cfg_mgmt_byte_enable <= '0;
      cfg_mgmt_read        <= 1'b0;
      cfg_mgmt_write       <= 1'b0;
    end else begin
      case (state)
        fixup_reading: begin
          if (!cfg_mgmt_read) begin  // first cycle out of reset
            cfg_mgmt_addr        <= fixup_addr;
            cfg_mgmt_byte_enable <= '1;  // whole dword
            cfg_mgmt_read        <= 1'b1;
          end else if (cfg_mgmt_read_write_done) begin
            cfg_mgmt_read       <= 1'b0;
            cfg_mgmt_write      <= 1'b1;
            cfg_mgmt_write_data <= cfg_mgmt_read_data | disable_mask;  // keep other bits
            state               <= fixup_writing;
          end
        end

        fixup_writing: begin
          if (cfg_mgmt_read_write_done) begin
            cfg_mgmt_addr        <= '0;
            cfg_mgmt_write_data  <= '0;
            cfg_mgmt_byte_enable <= '0;
            cfg_mgmt_write       <= 1'b0;
            state                <= fixup_finished;
          end
        end

        fixup_finished: begin
          // stray done pulses land here and are dropped
        end

        default: begin
          state <= fixup_finished;  // unused encoding
        end
      endcase
    end
  end

  // ------------------------------
  // protocol checks
  // ------------------------------

  // only one access may be outstanding on the port
  assert property (@(posedge user_clk) disable iff (user_reset)
    !(cfg_mgmt_read && cfg_mgmt_write))
    else $error("management read and write strobes high together");

  // a strobe may only drop on the edge that sampled done
  assert property (@(posedge user_clk) disable iff (user_reset)
    (!$past(user_reset) && $fell(cfg_mgmt_read)) |-> $past(cfg_mgmt_read_write_done))
    else $error("management read dropped before done");

  assert property (@(posedge user_clk) disable iff (user_reset)
    (!$past(user_reset) && $fell(cfg_mgmt_write)) |-> $past(cfg_mgmt_read_write_done))
    else $error("management write dropped before done");

endmodule

// File: src/pcie_cfg_pkg.sv
// types sized from the defs header; edit the macros there, not the typedefs here
`include "pcie_cfg_defs.svh"

package pcie_cfg_pkg;

  // ------------------------------
  // management port fields
  // ------------------------------

  typedef logic [`CFG_MGMT_ADDR_W-1:0] cfg_addr_t;  // config space dword address
  typedef logic [`CFG_DATA_W-1:0] cfg_data_t;       // register contents
  typedef logic [`CFG_BE_W-1:0] cfg_be_t;           // byte lanes

  // ------------------------------
  // per-function masks
  // ------------------------------

  typedef logic [`PF_COUNT-1:0] pf_mask_t;  // bit n is physical function n
  typedef logic [`VF_COUNT-1:0] vf_mask_t;  // bit n is virtual function n

  // ------------------------------
  // fix-up sequencer states
  // ------------------------------

  // reading covers both the idle cycle right after reset and the
  // wait for the read to complete
  typedef enum logic [1:0] {
    fixup_reading  = 2'd0,  // read issued or about to be
    fixup_writing  = 2'd1,  // merged value going back
    fixup_finished = 2'd2   // parked until next reset
  } fixup_state_t;

endpackage

// File: src/pcie_cfg_defs.svh
// widths and addresses match the 7-series gen3 core with 2 PFs and 6 VFs; other cores need edits
`ifndef PCIE_CFG_DEFS_SVH
`define PCIE_CFG_DEFS_SVH

// ------------------------------
// management port widths
// ------------------------------

`define CFG_MGMT_ADDR_W 19  // dword address into the core's config space
`define CFG_DATA_W 32       // read and write data
`define CFG_BE_W 4          // one enable per data byte

// ------------------------------
// function counts
// ------------------------------

`define PF_COUNT 2  // physical functions on the core
`define VF_COUNT 6  // virtual functions across all PFs

// ------------------------------
// skp lfsr fix-up target
// ------------------------------

// The core's receiver updates its LFSR from SKP ordered sets unless
// this bit is set. Some link partners send SKPs that upset the
// scrambler, so the bit is forced on once after every reset.
`define SKP_LFSR_REG_ADDR 19'h40082  // control register holding the bit
`define SKP_LFSR_DISABLE_BIT 27      // disable lfsr update from skp

`endif
